// File: src.f
logic/arm_dp_pkg.sv
logic/operand_fetch.sv
logic/alu_datapath.sv
logic/result_writeback.sv
logic/dp_exec_unit.sv
sim/dp_exec_unit_tb.sv

// File: Makefile
# Verilator build and run for the data-processing execution unit

VERILATOR ?= verilator
TOP       ?= dp_exec_unit_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
FAIL_MSG  ?= tests failed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS FAIL_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/dp_vectors.txt
// imm op s rn rd op2 | rn_val rm_val psr | reg_wr_en reg_wr_data restore | psr_wr_en psr_wr_value
// all hex; psr is n z c v in bits 31..28, mode in bits 2..0
0 4 1 1 2 003 00000005 00000007 00000010 1 0000000c 0 1 00000010
1 4 1 4 5 001 ffffffff 00000000 00000013 1 00000000 0 1 60000013
0 4 1 6 7 008 7fffffff 00000001 f0000000 1 80000000 0 1 90000000
1 4 0 1 1 0ff 00000100 00000000 00000000 1 000001ff 0 0 00000000
0 2 1 2 3 004 0000000a 00000003 00000000 1 00000007 0 1 20000000
1 2 1 9 a 005 00000003 00000000 20000000 1 fffffffe 0 1 80000000
0 2 1 b c 00d 80000000 00000001 00000000 1 7fffffff 0 1 30000000
0 0 1 3 4 005 f0f0f0f0 0ff00ff0 f0000012 1 00f000f0 0 1 30000012
1 0 1 6 6 00f 000000f0 00000000 00000000 1 00000000 0 1 40000000
1 d 1 7 8 abc 12345678 00000000 a0000001 1 00000abc 0 1 20000001
0 d 0 2 a 009 00000000 87654321 00000000 1 87654321 0 0 00000000
0 a 0 1 0 002 00000005 00000005 00000000 0 00000000 0 1 60000000
1 a 1 3 0 002 00000001 00000000 70000000 0 00000000 0 1 80000000
1 d 1 0 f 010 00000000 00000000 00000003 1 00000010 1 1 00000003
1 4 1 1 f 004 00001000 00000000 00000001 1 00001004 0 1 00000001
1 2 0 2 f 008 00000008 00000000 00000002 1 00000000 0 0 00000000
0 4 1 4 f 004 00000002 00000002 00000000 1 00000004 0 1 00000000
0 2 1 5 f 006 00000010 00000010 00000007 1 00000000 1 1 60000007
1 f 1 1 2 001 00000001 00000000 00000000 0 00000000 0 0 00000000
0 1 0 3 4 005 00000011 00000022 00000000 0 00000000 0 0 00000000

// File: sim/dp_exec_unit_tb.sv
`default_nettype none

module dp_exec_unit_tb;
    import arm_dp_pkg::*;

    localparam int vec_cols  = 14;
    localparam int max_vecs  = 64;
    localparam int done_wait = 100;
    localparam int quiet_cyc = 16;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              start;
    dp_cmd_t           cmd;
    reg_rd_req_t       reg_rd;
    logic [data_w-1:0] reg_rd_data = '0;
    logic              psr_rd_en;
    psr_t              psr_rd_data = '0;
    reg_wr_t           reg_wr;
    psr_wr_t           psr_wr;
    logic              busy;
    logic              done;

    logic [31:0] vec_mem [0:vec_cols*max_vecs-1];

    // values the register file model answers with
    logic [reg_idx_w-1:0] cur_rn;
    logic [data_w-1:0]    rn_val;
    logic [data_w-1:0]    rm_val;
    psr_t                 psr_val;

    // running totals, only ever incremented by the monitor
    int                   done_cnt = 0;
    int                   psr_rd_cnt = 0;
    int                   reg_wr_cnt = 0;
    int                   psr_wr_cnt = 0;
    reg_wr_t              last_reg_wr = '0;
    psr_t                 last_psr = '0;
    logic [reg_idx_w-1:0] rd_idx_q[$];

    int   vec_errs;
    int   pass_cnt;
    int   fail_cnt;
    logic hung;

    dp_exec_unit dp_exec_unit_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .cmd         (cmd),
        .reg_rd      (reg_rd),
        .reg_rd_data (reg_rd_data),
        .psr_rd_en   (psr_rd_en),
        .psr_rd_data (psr_rd_data),
        .reg_wr      (reg_wr),
        .psr_wr      (psr_wr),
        .busy        (busy),
        .done        (done)
    );

    always #20 clk = ~clk;

    // register file and status register model, plus the write monitor
    always @(posedge clk) begin
        logic        psr_req;
        reg_rd_req_t rd_req;
        psr_req = psr_rd_en;
        rd_req  = reg_rd;
        if (psr_rd_en) begin
            psr_rd_cnt++;
        end
        if (reg_rd.en) begin
            rd_idx_q.push_back(reg_rd.idx);
        end
        if (reg_wr.en) begin
            reg_wr_cnt++;
            last_reg_wr = reg_wr;
        end
        if (psr_wr.en) begin
            psr_wr_cnt++;
            last_psr = psr_wr.value;
        end
        if (done) begin
            done_cnt++;
        end
        #1;
        if (psr_req) begin
            psr_rd_data = psr_val;
        end
        if (rd_req.en) begin
            reg_rd_data = (rd_req.idx == cur_rn) ? rn_val : rm_val;
        end
    end

    task automatic report_mismatch(input string test, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("Error %s %s: expected %h, actual %h", test, what, exp, act);
        vec_errs++;
    endtask

    task automatic run_vector(input int v);
        int                   base;
        int                   wait_cnt;
        int                   done_base;
        int                   psr_rd_base;
        int                   reg_wr_base;
        int                   psr_wr_base;
        int                   rd_base;
        int                   exp_wr_cnt;
        int                   exp_psr_cnt;
        logic [data_w-1:0]    exp_wr_data;
        logic                 exp_restore;
        psr_t                 exp_psr;
        dp_cmd_t              c;
        dp_cmd_t              junk;
        logic [reg_idx_w-1:0] exp_idx[$];
        string                name;

        base         = v * vec_cols;
        name         = $sformatf("vec%0d", v);
        c.imm        = vec_mem[base][0];
        c.opcode     = alu_op_e'(vec_mem[base+1][3:0]);
        c.s          = vec_mem[base+2][0];
        c.rn         = vec_mem[base+3][3:0];
        c.rd         = vec_mem[base+4][3:0];
        c.op2.imm    = vec_mem[base+5][op2_w-1:0];
        rn_val       = vec_mem[base+6];
        rm_val       = vec_mem[base+7];
        psr_val      = vec_mem[base+8];
        exp_wr_cnt   = int'(vec_mem[base+9]);
        exp_wr_data  = vec_mem[base+10];
        exp_restore  = vec_mem[base+11][0];
        exp_psr_cnt  = int'(vec_mem[base+12]);
        exp_psr      = vec_mem[base+13];
        cur_rn       = c.rn;

        // rn is read unless MOV, rm unless the operand is immediate
        if (c.opcode != op_mov) begin
            exp_idx.push_back(c.rn);
        end
        if (!c.imm) begin
            exp_idx.push_back(c.op2.reg_op.rm);
        end

        vec_errs    = 0;
        done_base   = done_cnt;
        psr_rd_base = psr_rd_cnt;
        reg_wr_base = reg_wr_cnt;
        psr_wr_base = psr_wr_cnt;
        rd_base     = rd_idx_q.size();

        start = 1'b1;
        cmd   = c;
        @(posedge clk);
        #1;
        start = 1'b0;
        @(posedge clk);
        #1;
        if (!busy) begin
            report_mismatch(name, "busy during fetch", 1, 32'(busy));
        end
        // this one lands mid-fetch and must be dropped
        junk.imm     = 1'b1;
        junk.opcode  = op_add;
        junk.s       = 1'b1;
        junk.rn      = 4'h7;
        junk.rd      = 4'h7;
        junk.op2.imm = 12'h123;
        start = 1'b1;
        cmd   = junk;
        @(posedge clk);
        #1;
        start = 1'b0;

        wait_cnt = 0;
        while (done_cnt == done_base && wait_cnt < done_wait) begin
            @(posedge clk);
            #1;
            wait_cnt++;
        end
        if (done_cnt == done_base) begin
            $display("%s: no done pulse after %0d cycles", name, done_wait);
            hung = 1'b1;
            vec_errs++;
        end else begin
            // a second done would show up inside this window
            repeat (quiet_cyc) @(posedge clk);
            #1;
            if (done_cnt - done_base != 1) begin
                report_mismatch(name, "done pulses", 1, done_cnt - done_base);
            end
            if (psr_rd_cnt - psr_rd_base != 1) begin
                report_mismatch(name, "status reads", 1, psr_rd_cnt - psr_rd_base);
            end
            if (reg_wr_cnt - reg_wr_base != exp_wr_cnt) begin
                report_mismatch(name, "register writes", exp_wr_cnt, reg_wr_cnt - reg_wr_base);
            end else if (exp_wr_cnt == 1) begin
                if (last_reg_wr.idx != c.rd) begin
                    report_mismatch(name, "write index", 32'(c.rd), 32'(last_reg_wr.idx));
                end
                if (last_reg_wr.data != exp_wr_data) begin
                    report_mismatch(name, "write data", exp_wr_data, last_reg_wr.data);
                end
                if (last_reg_wr.restore != exp_restore) begin
                    report_mismatch(name, "restore", 32'(exp_restore),
                                    32'(last_reg_wr.restore));
                end
            end
            if (psr_wr_cnt - psr_wr_base != exp_psr_cnt) begin
                report_mismatch(name, "status writes", exp_psr_cnt, psr_wr_cnt - psr_wr_base);
            end else if (exp_psr_cnt == 1 && last_psr != exp_psr) begin
                report_mismatch(name, "status value", exp_psr, last_psr);
            end
            if (rd_idx_q.size() - rd_base != exp_idx.size()) begin
                report_mismatch(name, "register reads", exp_idx.size(),
                                rd_idx_q.size() - rd_base);
            end else begin
                for (int i = 0; i < exp_idx.size(); i++) begin
                    if (rd_idx_q[rd_base+i] != exp_idx[i]) begin
                        report_mismatch(name, "read index", 32'(exp_idx[i]),
                                        32'(rd_idx_q[rd_base+i]));
                    end
                end
            end
        end

        if (vec_errs == 0) begin
            pass_cnt++;
            $display("%s opcode %h rd %h: pass", name, c.opcode, c.rd);
        end else begin
            fail_cnt++;
            $display("%s opcode %h rd %h: FAIL", name, c.opcode, c.rd);
        end
    endtask

    initial begin
        int v;
        rst_n    = 1'b0;
        start    = 1'b0;
        cmd      = '0;
        cur_rn   = '0;
        rn_val   = '0;
        rm_val   = '0;
        psr_val  = '0;
        vec_errs = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        hung     = 1'b0;
        // inverted address marks slots the file left empty
        for (int i = 0; i < vec_cols * max_vecs; i++) begin
            vec_mem[i] = ~32'(i);
        end
        $readmemh("sim/dp_vectors.txt", vec_mem);

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        v = 0;
        while (v < max_vecs && !hung && vec_mem[v*vec_cols] != ~32'(v*vec_cols)) begin
            run_vector(v);
            v++;
        end

        $display("%0d tests run, %0d passed, %0d failed",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt);
        if (fail_cnt == 0 && pass_cnt > 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/dp_exec_unit.sv
`default_nettype none

module dp_exec_unit (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          start,
    input  wire arm_dp_pkg::dp_cmd_t     cmd,
    output arm_dp_pkg::reg_rd_req_t      reg_rd,
    input  wire [arm_dp_pkg::data_w-1:0] reg_rd_data,
    output logic                         psr_rd_en,
    input  wire arm_dp_pkg::psr_t        psr_rd_data,
    output arm_dp_pkg::reg_wr_t          reg_wr,
    output arm_dp_pkg::psr_wr_t          psr_wr,
    output logic                         busy,
    output logic                         done
);
    import arm_dp_pkg::*;

    logic       fetch_valid;
    fetch_out_t fetch_out;
    logic       alu_valid;
    alu_out_t   alu_out;

    operand_fetch operand_fetch_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .cmd         (cmd),
        .done        (done),
        .busy        (busy),
        .reg_rd      (reg_rd),
        .reg_rd_data (reg_rd_data),
        .psr_rd_en   (psr_rd_en),
        .psr_rd_data (psr_rd_data),
        .fetch_valid (fetch_valid),
        .fetch_out   (fetch_out)
    );

    alu_datapath alu_datapath_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_out   (fetch_out),
        .alu_valid   (alu_valid),
        .alu_out     (alu_out)
    );

    result_writeback result_writeback_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .alu_valid (alu_valid),
        .alu_out   (alu_out),
        .reg_wr    (reg_wr),
        .psr_wr    (psr_wr),
        .done      (done)
    );

endmodule

`default_nettype wire

// File: logic/result_writeback.sv
`default_nettype none

module result_writeback (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         alu_valid,
    input  wire arm_dp_pkg::alu_out_t   alu_out,
    output arm_dp_pkg::reg_wr_t         reg_wr,
    output arm_dp_pkg::psr_wr_t         psr_wr,
    output logic                        done
);
    import arm_dp_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_reg,
        st_psr,
        st_done
    } state_e;

    state_e   state;
    alu_out_t hold_q;
    psr_t     psr_next;

    function automatic logic wants_reg(input dp_cmd_t c);
        return (c.opcode == op_add) || (c.opcode == op_sub) ||
               (c.opcode == op_and) || (c.opcode == op_mov);
    endfunction

    // unknown opcodes never touch the status register
    function automatic logic wants_psr(input dp_cmd_t c);
        logic known;
        known = wants_reg(c) || (c.opcode == op_cmp);
        return known && (c.s || (c.opcode == op_cmp));
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (alu_valid) begin
                        if (wants_reg(alu_out.cmd)) begin
                            state <= st_reg;
                        end else if (wants_psr(alu_out.cmd)) begin
                            state <= st_psr;
                        end else begin
                            state <= st_done;
                        end
                    end
                end
                st_reg: state <= wants_psr(hold_q.cmd) ? st_psr : st_done;
                st_psr: state <= st_done;
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alu_valid) begin
            hold_q <= alu_out;
        end
    end

    // new flags over the status word that was read
    always_comb begin
        psr_next   = hold_q.psr;
        psr_next.n = hold_q.flags.n;
        psr_next.z = hold_q.flags.z;
        psr_next.c = hold_q.flags.c;
        psr_next.v = hold_q.flags.v;
    end

    assign reg_wr.en      = (state == st_reg);
    assign reg_wr.idx     = hold_q.cmd.rd;
    assign reg_wr.data    = hold_q.result;
    // user and fiq-less modes have no saved status
    assign reg_wr.restore = (hold_q.cmd.rd == pc_reg) && hold_q.cmd.s &&
                            (hold_q.mode != 3'b000) && (hold_q.mode != 3'b001);

    assign psr_wr.en    = (state == st_psr);
    assign psr_wr.value = psr_next;
    assign done         = (state == st_done);

endmodule

`default_nettype wire

// File: logic/alu_datapath.sv
`default_nettype none

module alu_datapath (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire                            fetch_valid,
    input  wire arm_dp_pkg::fetch_out_t    fetch_out,
    output logic                           alu_valid,
    output arm_dp_pkg::alu_out_t           alu_out
);
    import arm_dp_pkg::*;

    logic [data_w:0]   sum;
    logic [data_w:0]   diff;
    logic [data_w-1:0] result;
    logic              a_msb;
    logic              b_msb;
    flags_t            flags;

    assign sum   = {1'b0, fetch_out.op1} + {1'b0, fetch_out.op2};
    assign diff  = {1'b0, fetch_out.op1} - {1'b0, fetch_out.op2};
    assign a_msb = fetch_out.op1[data_w-1];
    assign b_msb = fetch_out.op2[data_w-1];

    always_comb begin
        result  = '0;
        flags.c = fetch_out.psr.c;
        flags.v = fetch_out.psr.v;
        case (fetch_out.cmd.opcode)
            op_add: begin
                result  = sum[data_w-1:0];
                flags.c = sum[data_w];
                flags.v = ~(a_msb ^ b_msb) & (a_msb ^ result[data_w-1]);
            end
            op_sub, op_cmp: begin
                result  = diff[data_w-1:0];
                // carry is not-borrow
                flags.c = ~diff[data_w];
                flags.v = (a_msb ^ b_msb) & (a_msb ^ result[data_w-1]);
            end
            op_and: result = fetch_out.op1 & fetch_out.op2;
            op_mov: result = fetch_out.op2;
            default: result = '0;
        endcase
        flags.n = result[data_w-1];
        flags.z = (result == '0);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            alu_out.cmd    <= fetch_out.cmd;
            alu_out.mode   <= fetch_out.psr.mode;
            alu_out.result <= result;
            alu_out.flags  <= flags;
            alu_out.psr    <= fetch_out.psr;
        end
    end

endmodule

`default_nettype wire

// File: logic/operand_fetch.sv
`default_nettype none

module operand_fetch (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          start,
    input  wire arm_dp_pkg::dp_cmd_t     cmd,
    input  wire                          done,
    output logic                         busy,
    output arm_dp_pkg::reg_rd_req_t      reg_rd,
    input  wire [arm_dp_pkg::data_w-1:0] reg_rd_data,
    output logic                         psr_rd_en,
    input  wire arm_dp_pkg::psr_t        psr_rd_data,
    output logic                         fetch_valid,
    output arm_dp_pkg::fetch_out_t       fetch_out
);
    import arm_dp_pkg::*;

    typedef enum logic [3:0] {
        st_idle,
        st_psr_req,
        st_psr_wait,
        st_rn_req,
        st_rn_wait,
        st_rm_req,
        st_rm_wait,
        st_emit,
        st_hold
    } state_e;

    state_e     state;
    fetch_out_t fetch_q;
    logic       accept;

    // busy falls together with done so a new start can land right away
    assign busy   = (state != st_idle) && !done;
    assign accept = start && !busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else if (accept) begin
            state <= st_psr_req;
        end else begin
            case (state)
                st_psr_req: state <= st_psr_wait;
                st_psr_wait: begin
                    if (fetch_q.cmd.opcode != op_mov) begin
                        state <= st_rn_req;
                    end else if (!fetch_q.cmd.imm) begin
                        state <= st_rm_req;
                    end else begin
                        state <= st_emit;
                    end
                end
                st_rn_req: state <= st_rn_wait;
                st_rn_wait: begin
                    if (fetch_q.cmd.imm) begin
                        state <= st_emit;
                    end else begin
                        state <= st_rm_req;
                    end
                end
                st_rm_req: state <= st_rm_wait;
                st_rm_wait: state <= st_emit;
                st_emit: state <= st_hold;
                st_hold: begin
                    if (done) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // op1 zero covers MOV, immediate op2 is zero-extended with no rotate
    always_ff @(posedge clk) begin
        if (accept) begin
            fetch_q.cmd <= cmd;
            fetch_q.op1 <= '0;
            fetch_q.op2 <= {{(data_w-op2_w){1'b0}}, cmd.op2.imm};
        end
        if (state == st_psr_wait) begin
            fetch_q.psr <= psr_rd_data;
        end
        if (state == st_rn_wait) begin
            fetch_q.op1 <= reg_rd_data;
        end
        if (state == st_rm_wait) begin
            fetch_q.op2 <= reg_rd_data;
        end
    end

    assign psr_rd_en   = (state == st_psr_req);
    assign reg_rd.en   = (state == st_rn_req) || (state == st_rm_req);
    assign reg_rd.idx  = (state == st_rm_req) ? fetch_q.cmd.op2.reg_op.rm : fetch_q.cmd.rn;
    assign fetch_valid = (state == st_emit);
    assign fetch_out   = fetch_q;

endmodule

`default_nettype wire

// File: logic/arm_dp_pkg.sv
`default_nettype none

package arm_dp_pkg;

    localparam int data_w    = 32;
    localparam int reg_idx_w = 4;
    localparam int op2_w     = 12;

    localparam logic [reg_idx_w-1:0] pc_reg = reg_idx_w'(15);

    // data-processing opcodes handled here
    typedef enum logic [3:0] {
        op_and = 4'b0000,
        op_sub = 4'b0010,
        op_add = 4'b0100,
        op_cmp = 4'b1010,
        op_mov = 4'b1101
    } alu_op_e;

    // immediate value, or rm in the low nibble
    typedef union packed {
        logic [op2_w-1:0] imm;
        struct packed {
            logic [op2_w-reg_idx_w-1:0] unused;
            logic [reg_idx_w-1:0]       rm;
        } reg_op;
    } operand2_u;

    typedef struct packed {
        logic                 imm;
        alu_op_e              opcode;
        logic                 s;
        logic [reg_idx_w-1:0] rn;
        logic [reg_idx_w-1:0] rd;
        operand2_u            op2;
    } dp_cmd_t;

    typedef struct packed {
        logic        n;
        logic        z;
        logic        c;
        logic        v;
        logic [24:0] reserved;
        logic [2:0]  mode;
    } psr_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        logic                 en;
        logic [reg_idx_w-1:0] idx;
    } reg_rd_req_t;

    typedef struct packed {
        logic                 en;
        logic [reg_idx_w-1:0] idx;
        logic [data_w-1:0]    data;
        logic                 restore;
    } reg_wr_t;

    typedef struct packed {
        logic en;
        psr_t value;
    } psr_wr_t;

    typedef struct packed {
        dp_cmd_t           cmd;
        logic [data_w-1:0] op1;
        logic [data_w-1:0] op2;
        psr_t              psr;
    } fetch_out_t;

    typedef struct packed {
        dp_cmd_t           cmd;
        logic [2:0]        mode;
        logic [data_w-1:0] result;
        flags_t            flags;
        psr_t              psr;
    } alu_out_t;

endpackage

`default_nettype wire
